/* verilog/pipePkg.sv */
package pipePkg;

    // register file addressing
    localparam int regAddrW = 5;
    localparam int regCount = 1 << regAddrW;

    // field widths for the encoded types below
    localparam int instKindW = 3;
    localparam int fwdSelW = 2;

    // what kind of result an instruction in a stage will produce
    typedef enum logic [instKindW-1:0] {
        kindNone, // bubble
        kindAlu,
        kindLoad, // memory read, data not ready until M
        kindMfc, // cp0 read
        kindHilo // hi/lo read
    } instKind;

    // decode operand source
    // fixed 2-bit encoding, zero selects the register file
    typedef enum logic [fwdSelW-1:0] {
        fwdNone = 2'd0, // register file
        fwdMem = 2'd1,
        fwdWb = 2'd2,
        fwdEx = 2'd3
    } fwdSel;

endpackage

/* verilog/hazardUnit.sv */
module hazardUnit (
    input logic iCacheStall,
    input logic dCacheStall,
    input logic aluStallE,
    input logic flushJumpConflictE,
    input logic flushPredFailedM,
    input logic flushExceptionM,
    input logic [pipePkg::regAddrW-1:0] rsD,
    input logic [pipePkg::regAddrW-1:0] rtD,
    input logic regWriteE,
    input logic regWriteM,
    input logic regWriteW,
    input logic [pipePkg::regAddrW-1:0] writeRegE,
    input logic [pipePkg::regAddrW-1:0] writeRegM,
    input logic [pipePkg::regAddrW-1:0] writeRegW,
    input pipePkg::instKind kindE,
    output logic stallF,
    output logic stallD,
    output logic stallE,
    output logic stallM,
    output logic stallW,
    output logic flushF,
    output logic flushD,
    output logic flushE,
    output logic flushM,
    output logic flushW,
    output logic longestStall,
    output logic stallDblank,
    output pipePkg::fwdSel forward1D,
    output pipePkg::fwdSel forward2D
);

    logic cacheStall;
    logic lateResultE; // E result not available until M or later

    // youngest matching writer wins, r0 never forwards
    function automatic pipePkg::fwdSel pickForward(input logic [pipePkg::regAddrW-1:0] src);
        pipePkg::fwdSel sel;
        sel = pipePkg::fwdNone;
        if (src != '0) begin
            if (regWriteE && src == writeRegE)
                sel = pipePkg::fwdEx;
            else if (regWriteM && src == writeRegM)
                sel = pipePkg::fwdMem;
            else if (regWriteW && src == writeRegW)
                sel = pipePkg::fwdWb;
        end
        return sel;
    endfunction

    always_comb begin
        forward1D = pickForward(rsD);
        forward2D = pickForward(rtD);
    end

    // lw, mfc0 and mfhi/mflo all resolve after E
    assign lateResultE = (kindE == pipePkg::kindLoad) || (kindE == pipePkg::kindMfc) ||
                         (kindE == pipePkg::kindHilo);

    assign cacheStall = iCacheStall | dCacheStall;
    assign longestStall = cacheStall | aluStallE;

    // load-use style hazard, exception takes precedence
    assign stallDblank = (forward1D == pipePkg::fwdEx || forward2D == pipePkg::fwdEx) &&
                         lateResultE && !flushExceptionM;

    assign stallF = (~flushExceptionM & (cacheStall | aluStallE)) | stallDblank;
    assign stallD = cacheStall | aluStallE | stallDblank;
    assign stallE = cacheStall | aluStallE;
    assign stallM = cacheStall;
    assign stallW = ~flushExceptionM & cacheStall; // W must drain on exception

    assign flushF = 1'b0;
    assign flushD = flushExceptionM | flushPredFailedM | (flushJumpConflictE & ~stallD);
    assign flushE = flushExceptionM | (flushPredFailedM & ~aluStallE) | (~stallE & stallDblank);
    assign flushM = flushExceptionM;
    assign flushW = flushExceptionM;

endmodule

/* verilog/stageTracker.sv */
module stageTracker (
    input logic clk,
    input logic rstN,
    input logic regWriteD,
    input logic [pipePkg::regAddrW-1:0] writeRegD,
    input pipePkg::instKind kindD,
    input logic stallE,
    input logic stallM,
    input logic stallW,
    input logic flushE,
    input logic flushM,
    input logic flushW,
    output logic regWriteE,
    output logic regWriteM,
    output logic regWriteW,
    output logic [pipePkg::regAddrW-1:0] writeRegE,
    output logic [pipePkg::regAddrW-1:0] writeRegM,
    output logic [pipePkg::regAddrW-1:0] writeRegW,
    output pipePkg::instKind kindE
);

    // each stage: flush clears to a bubble, else stall holds, else advance

    // E stage, the only one that needs the kind
    always_ff @(posedge clk) begin
        if (!rstN) begin
            regWriteE <= 1'b0;
            writeRegE <= '0;
            kindE <= pipePkg::kindNone;
        end else if (flushE) begin
            regWriteE <= 1'b0;
            writeRegE <= '0;
            kindE <= pipePkg::kindNone;
        end else if (!stallE) begin
            regWriteE <= regWriteD;
            writeRegE <= writeRegD;
            kindE <= kindD;
        end
    end

    // M stage
    always_ff @(posedge clk) begin
        if (!rstN) begin
            regWriteM <= 1'b0;
            writeRegM <= '0;
        end else if (flushM) begin
            regWriteM <= 1'b0;
            writeRegM <= '0;
        end else if (!stallM) begin
            regWriteM <= regWriteE;
            writeRegM <= writeRegE;
        end
    end

    // W stage, also feeds the register file write port
    always_ff @(posedge clk) begin
        if (!rstN) begin
            regWriteW <= 1'b0;
            writeRegW <= '0;
        end else if (flushW) begin
            regWriteW <= 1'b0;
            writeRegW <= '0;
        end else if (!stallW) begin
            regWriteW <= regWriteM;
            writeRegW <= writeRegM;
        end
    end

endmodule

/* verilog/operandForward.sv */
module operandForward #(
    parameter int dataW = 32
) (
    input pipePkg::fwdSel forward1D,
    input pipePkg::fwdSel forward2D,
    input logic [dataW-1:0] regData1,
    input logic [dataW-1:0] regData2,
    input logic [dataW-1:0] resultE,
    input logic [dataW-1:0] resultM,
    input logic [dataW-1:0] resultW,
    output logic [dataW-1:0] operand1D,
    output logic [dataW-1:0] operand2D
);

    // one mux per operand, same source buses
    function automatic logic [dataW-1:0] selectSource(
        input pipePkg::fwdSel sel,
        input logic [dataW-1:0] regData
    );
        logic [dataW-1:0] value;
        case (sel)
            pipePkg::fwdEx: value = resultE;
            pipePkg::fwdMem: value = resultM;
            pipePkg::fwdWb: value = resultW;
            default: value = regData; // fwdNone
        endcase
        return value;
    endfunction

    always_comb begin
        operand1D = selectSource(forward1D, regData1);
        operand2D = selectSource(forward2D, regData2);
    end

endmodule

/* verilog/regFile.sv */
module regFile #(
    parameter int dataW = 32
) (
    input logic clk,
    input logic rstN,
    input logic [pipePkg::regAddrW-1:0] readAddr1,
    input logic [pipePkg::regAddrW-1:0] readAddr2,
    input logic writeEn,
    input logic [pipePkg::regAddrW-1:0] writeAddr,
    input logic [dataW-1:0] writeData,
    input logic hold, // W stage stalled
    output logic [dataW-1:0] readData1,
    output logic [dataW-1:0] readData2
);

    logic [dataW-1:0] regs [pipePkg::regCount];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < pipePkg::regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && !hold && writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

    // async read, same-cycle W match is handled by the forwarder
    assign readData1 = (readAddr1 == '0) ? '0 : regs[readAddr1];
    assign readData2 = (readAddr2 == '0) ? '0 : regs[readAddr2];

endmodule

/* verilog/pipeControlTop.sv */
module pipeControlTop #(
    parameter int dataW = 32
) (
    input logic clk,
    input logic rstN,
    input logic [pipePkg::regAddrW-1:0] rsD,
    input logic [pipePkg::regAddrW-1:0] rtD,
    input logic regWriteD,
    input logic [pipePkg::regAddrW-1:0] writeRegD,
    input pipePkg::instKind kindD,
    input logic iCacheStall,
    input logic dCacheStall,
    input logic aluStallE,
    input logic flushJumpConflictE,
    input logic flushPredFailedM,
    input logic flushExceptionM,
    input logic [dataW-1:0] resultE,
    input logic [dataW-1:0] resultM,
    input logic [dataW-1:0] resultW,
    output logic stallF,
    output logic stallD,
    output logic stallE,
    output logic stallM,
    output logic stallW,
    output logic flushF,
    output logic flushD,
    output logic flushE,
    output logic flushM,
    output logic flushW,
    output logic longestStall,
    output logic stallDblank,
    output pipePkg::fwdSel forward1D,
    output pipePkg::fwdSel forward2D,
    output logic [dataW-1:0] operand1D,
    output logic [dataW-1:0] operand2D
);

    // downstream destination info
    logic regWriteE, regWriteM, regWriteW;
    logic [pipePkg::regAddrW-1:0] writeRegE, writeRegM, writeRegW;
    pipePkg::instKind kindE;

    logic [dataW-1:0] regData1, regData2;

    hazardUnit hazard (
        .iCacheStall(iCacheStall), .dCacheStall(dCacheStall), .aluStallE(aluStallE),
        .flushJumpConflictE(flushJumpConflictE), .flushPredFailedM(flushPredFailedM),
        .flushExceptionM(flushExceptionM),
        .rsD(rsD), .rtD(rtD),
        .regWriteE(regWriteE), .regWriteM(regWriteM), .regWriteW(regWriteW),
        .writeRegE(writeRegE), .writeRegM(writeRegM), .writeRegW(writeRegW),
        .kindE(kindE),
        .stallF(stallF), .stallD(stallD), .stallE(stallE), .stallM(stallM), .stallW(stallW),
        .flushF(flushF), .flushD(flushD), .flushE(flushE), .flushM(flushM), .flushW(flushW),
        .longestStall(longestStall), .stallDblank(stallDblank),
        .forward1D(forward1D), .forward2D(forward2D)
    );

    stageTracker tracker (
        .clk(clk), .rstN(rstN),
        .regWriteD(regWriteD), .writeRegD(writeRegD), .kindD(kindD),
        .stallE(stallE), .stallM(stallM), .stallW(stallW),
        .flushE(flushE), .flushM(flushM), .flushW(flushW),
        .regWriteE(regWriteE), .regWriteM(regWriteM), .regWriteW(regWriteW),
        .writeRegE(writeRegE), .writeRegM(writeRegM), .writeRegW(writeRegW),
        .kindE(kindE)
    );

    operandForward #(.dataW(dataW)) fwd (
        .forward1D(forward1D), .forward2D(forward2D),
        .regData1(regData1), .regData2(regData2),
        .resultE(resultE), .resultM(resultM), .resultW(resultW),
        .operand1D(operand1D), .operand2D(operand2D)
    );

    // written from W, held while W is stalled
    regFile #(.dataW(dataW)) regs (
        .clk(clk), .rstN(rstN),
        .readAddr1(rsD), .readAddr2(rtD),
        .writeEn(regWriteW), .writeAddr(writeRegW), .writeData(resultW),
        .hold(stallW),
        .readData1(regData1), .readData2(regData2)
    );

endmodule

/* verification/pipeControlTb.sv */
module pipeControlTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int dataW = 32;
    localparam int aw = pipePkg::regAddrW;

    logic clk;
    logic rstN;
    logic [aw-1:0] rsD;
    logic [aw-1:0] rtD;
    logic [aw-1:0] writeRegD;
    logic regWriteD;
    pipePkg::instKind kindD;
    logic iCacheStall, dCacheStall, aluStallE;
    logic flushJumpConflictE, flushPredFailedM, flushExceptionM;
    logic [dataW-1:0] resultE, resultM, resultW;
    logic stallF, stallD, stallE, stallM, stallW;
    logic flushF, flushD, flushE, flushM, flushW;
    logic longestStall, stallDblank;
    pipePkg::fwdSel forward1D, forward2D;
    logic [dataW-1:0] operand1D, operand2D;

    // requested levels, applied on the next rising edge
    logic iCacheReq, dCacheReq, aluReq, jumpReq, predReq, excReq;
    logic regWriteReq;
    logic [aw-1:0] writeRegReq, rsReq, rtReq;
    pipePkg::instKind kindReq;

    integer seed;
    int errors, testStartErrors, testsRun, testsFailed;
    logic [dataW-1:0] wbValue; // resultW seen while the writer sat in W

    pipeControlTop #(.dataW(dataW)) uut (.*);

    always #2 clk = ~clk;

    // fetch is never flushed in this core
    fetchNeverFlushed: assert property (@(posedge clk) disable iff (!rstN) !flushF)
        else begin
            $display("flushF was raised although fetch is never flushed");
            errors++;
        end

    fetchStallImpliesDecode: assert property (@(posedge clk) disable iff (!rstN) stallF |-> stallD)
        else begin
            $display("stallF was high while stallD was low");
            errors++;
        end

    task automatic cycle();
        @(posedge clk);
        iCacheStall <= iCacheReq;
        dCacheStall <= dCacheReq;
        aluStallE <= aluReq;
        flushJumpConflictE <= jumpReq;
        flushPredFailedM <= predReq;
        flushExceptionM <= excReq;
        regWriteD <= regWriteReq;
        writeRegD <= writeRegReq;
        kindD <= kindReq;
        rsD <= rsReq;
        rtD <= rtReq;
        resultE <= $random(seed); // fresh bus values every cycle
        resultM <= $random(seed);
        resultW <= $random(seed);
        @(negedge clk); // outputs settled here
    endtask

    task automatic drive(input logic wr, input logic [aw-1:0] wreg, input pipePkg::instKind kind,
                         input logic [aw-1:0] rs, input logic [aw-1:0] rt);
        regWriteReq = wr;
        writeRegReq = wreg;
        kindReq = kind;
        rsReq = rs;
        rtReq = rt;
        cycle();
    endtask

    // bubbles through E, M and W with all controls released
    task automatic drain();
        iCacheReq = 1'b0;
        dCacheReq = 1'b0;
        aluReq = 1'b0;
        jumpReq = 1'b0;
        predReq = 1'b0;
        excReq = 1'b0;
        repeat (3) drive(1'b0, 5'd0, pipePkg::kindNone, 5'd0, 5'd0);
    endtask

    task automatic waitFwd1(input pipePkg::fwdSel want, input int limit);
        int n;
        n = 0;
        while (forward1D !== want && n < limit) begin
            cycle();
            n++;
        end
        if (forward1D !== want) begin
            $display("timeout: forward1D did not reach %s within %0d cycles", want.name(), limit);
            errors++;
        end
    endtask

    task automatic checkBit(input string name, input logic expected, input logic actual);
        assert (actual === expected)
            else begin
                $display("** Error: %s expected %h got %h", name, expected, actual);
                errors++;
            end
    endtask

    task automatic checkSel(input string name, input pipePkg::fwdSel expected,
                            input pipePkg::fwdSel actual);
        assert (actual === expected)
            else begin
                $display("** Error: %s expected %h got %h", name, expected, actual);
                errors++;
            end
    endtask

    task automatic checkWord(input string name, input logic [dataW-1:0] expected,
                             input logic [dataW-1:0] actual);
        assert (actual === expected)
            else begin
                $display("** Error: %s expected %h got %h", name, expected, actual);
                errors++;
            end
    endtask

    task automatic beginTest();
        testStartErrors = errors;
    endtask

    task automatic endTest(input string name);
        testsRun++;
        if (errors == testStartErrors) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: failed with %0d errors", name, errors - testStartErrors);
            testsFailed++;
        end
    endtask

    initial begin
        seed = 32'h81f0cba6;
        errors = 0;
        testsRun = 0;
        testsFailed = 0;
        clk = 1'b0;
        rstN <= 1'b0;
        rsD <= '0;
        rtD <= '0;
        writeRegD <= '0;
        regWriteD <= 1'b0;
        kindD <= pipePkg::kindNone;
        iCacheStall <= 1'b0;
        dCacheStall <= 1'b0;
        aluStallE <= 1'b0;
        flushJumpConflictE <= 1'b0;
        flushPredFailedM <= 1'b0;
        flushExceptionM <= 1'b0;
        resultE <= '0;
        resultM <= '0;
        resultW <= '0;
        iCacheReq = 1'b0;
        dCacheReq = 1'b0;
        aluReq = 1'b0;
        jumpReq = 1'b0;
        predReq = 1'b0;
        excReq = 1'b0;
        regWriteReq = 1'b0;
        writeRegReq = '0;
        kindReq = pipePkg::kindNone;
        rsReq = '0;
        rtReq = '0;
        wbValue = '0;

        repeat (16) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);

        // three writers of r5, then a reader
        beginTest();
        repeat (3) drive(1'b1, 5'd5, pipePkg::kindAlu, 5'd0, 5'd0);
        drive(1'b0, 5'd0, pipePkg::kindNone, 5'd5, 5'd0);
        waitFwd1(pipePkg::fwdEx, 4);
        checkWord("operand1D", resultE, operand1D);
        drive(1'b0, 5'd0, pipePkg::kindNone, 5'd5, 5'd0); // E now holds a non-writer
        checkSel("forward1D", pipePkg::fwdMem, forward1D);
        checkWord("operand1D", resultM, operand1D);
        drive(1'b0, 5'd0, pipePkg::kindNone, 5'd0, 5'd0);
        checkSel("forward1D", pipePkg::fwdNone, forward1D);
        checkWord("operand1D", 32'h0, operand1D);
        endTest("forwarding priority");

        beginTest();
        drain();
        drive(1'b1, 5'd7, pipePkg::kindLoad, 5'd0, 5'd0);
        drive(1'b0, 5'd0, pipePkg::kindNone, 5'd7, 5'd0);
        checkSel("forward1D", pipePkg::fwdEx, forward1D);
        checkBit("stallDblank", 1'b1, stallDblank);
        checkBit("stallF", 1'b1, stallF);
        checkBit("stallD", 1'b1, stallD);
        checkBit("flushE", 1'b1, flushE);
        cycle(); // bubble enters E, load moves to M
        checkSel("forward1D", pipePkg::fwdMem, forward1D);
        checkBit("stallDblank", 1'b0, stallDblank);
        endTest("load-use bubble");

        beginTest();
        drain();
        drive(1'b1, 5'd1, pipePkg::kindAlu, 5'd0, 5'd0);
        drive(1'b1, 5'd2, pipePkg::kindAlu, 5'd0, 5'd0);
        drive(1'b1, 5'd3, pipePkg::kindAlu, 5'd0, 5'd0);
        dCacheReq = 1'b1;
        drive(1'b0, 5'd0, pipePkg::kindNone, 5'd1, 5'd3);
        checkBit("stallF", 1'b1, stallF);
        checkBit("stallD", 1'b1, stallD);
        checkBit("stallE", 1'b1, stallE);
        checkBit("stallM", 1'b1, stallM);
        checkBit("stallW", 1'b1, stallW);
        checkBit("longestStall", 1'b1, longestStall);
        repeat (3) begin
            checkSel("forward1D", pipePkg::fwdWb, forward1D);
            checkSel("forward2D", pipePkg::fwdEx, forward2D);
            checkWord("operand2D", resultE, operand2D);
            cycle();
        end
        dCacheReq = 1'b0;
        aluReq = 1'b1;
        cycle();
        checkBit("stallF", 1'b1, stallF);
        checkBit("stallD", 1'b1, stallD);
        checkBit("stallE", 1'b1, stallE);
        checkBit("stallM", 1'b0, stallM);
        checkBit("stallW", 1'b0, stallW);
        endTest("cache and alu stalls");

        beginTest();
        drain();
        drive(1'b1, 5'd7, pipePkg::kindLoad, 5'd0, 5'd0);
        excReq = 1'b1;
        dCacheReq = 1'b1;
        drive(1'b0, 5'd0, pipePkg::kindNone, 5'd7, 5'd7);
        checkBit("flushD", 1'b1, flushD);
        checkBit("flushE", 1'b1, flushE);
        checkBit("flushM", 1'b1, flushM);
        checkBit("flushW", 1'b1, flushW);
        checkBit("stallDblank", 1'b0, stallDblank);
        checkBit("stallF", 1'b0, stallF);
        checkBit("stallW", 1'b0, stallW);
        excReq = 1'b0;
        dCacheReq = 1'b0;
        cycle();
        checkSel("forward1D", pipePkg::fwdNone, forward1D);
        checkSel("forward2D", pipePkg::fwdNone, forward2D);
        endTest("exception flush");

        beginTest();
        drain();
        jumpReq = 1'b1;
        cycle();
        checkBit("flushD", 1'b1, flushD);
        aluReq = 1'b1; // D stalled, jump conflict must not flush it
        cycle();
        checkBit("flushD", 1'b0, flushD);
        jumpReq = 1'b0;
        predReq = 1'b1;
        cycle();
        checkBit("flushD", 1'b1, flushD);
        checkBit("flushE", 1'b0, flushE);
        endTest("control-flow flushes");

        beginTest();
        drain();
        drive(1'b1, 5'd9, pipePkg::kindAlu, 5'd0, 5'd0);
        drive(1'b0, 5'd0, pipePkg::kindNone, 5'd9, 5'd0);
        waitFwd1(pipePkg::fwdWb, 6);
        wbValue = resultW;
        cycle(); // writer retires into the register file
        checkSel("forward1D", pipePkg::fwdNone, forward1D);
        checkWord("operand1D", wbValue, operand1D);
        endTest("write-back");

        $display("tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* sources.f */
verilog/pipePkg.sv
verilog/hazardUnit.sv
verilog/stageTracker.sv
verilog/operandForward.sv
verilog/regFile.sv
verilog/pipeControlTop.sv
verification/pipeControlTb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the pipeline control testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module pipeControlTb \
    -f sources.f \
    -Mdir obj_dir

output=$(./obj_dir/VpipeControlTb)
echo "$output"

if grep -qx ">>> PASS" <<< "$output"; then
    exit 0
fi

echo "simulation did not pass"
exit 1
